/* Bender.yml */
package:
  name: mips_core

sources:
  - logic/mips_pkg.sv
  - logic/fetch_unit.sv
  - logic/decode_stage.sv
  - logic/register_file.sv
  - logic/execute_stage.sv
  - logic/result_stage.sv
  - logic/mips_core.sv
  - target: simulation
    files:
      - bench/clock_gen.sv
      - bench/mips_core_tb.sv

/* bench/clock_gen.sv */
`default_nettype none
`timescale 1ns/10ps

module clock_gen #(
	parameter int HALF_PERIOD = 10,
	parameter int RESET_CYCLES = 5
) (
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD) clock = ~clock;
	end

	// Released on a falling edge, away from the sampling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* bench/mips_core_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module mips_core_tb import mips_pkg::*; ();

	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;
	localparam int MAX_EXP = 512;

	wire clock;
	wire rst_n;
	logic load_en;
	word_t load_addr;
	word_t load_data;
	logic start;
	word_t prog_len;
	logic retire_valid;
	reg_idx_t retire_reg;
	word_t retire_data;
	logic store_valid;
	word_t store_addr;
	word_t store_data;
	logic done;

	word_t prog [IMEM_WORDS];
	word_t model_regs [NUM_REGS];
	word_t model_mem [DMEM_WORDS];
	reg_idx_t exp_ret_reg [MAX_EXP];
	word_t exp_ret_data [MAX_EXP];
	word_t exp_st_addr [MAX_EXP];
	word_t exp_st_data [MAX_EXP];
	int ret_total = 0;
	int ret_seen = 0;
	int st_total = 0;
	int st_seen = 0;
	logic started = 1'b0;
	logic [31:0] lfsr_state = 32'he40d;

	funct_e r_functs [16] = '{F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR, F_XOR, F_NOR,
		F_SLT, F_SLTU, F_SLL, F_SRL, F_SRA, F_SLLV, F_SRLV, F_SRAV};
	opcode_e i_ops [7] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ORI, OP_XORI, OP_LUI};

	reg_idx_t head_ret_reg;
	word_t head_ret_data, head_st_addr, head_st_data;

	assign head_ret_reg = exp_ret_reg[ret_seen];
	assign head_ret_data = exp_ret_data[ret_seen];
	assign head_st_addr = exp_st_addr[st_seen];
	assign head_st_data = exp_st_data[st_seen];

	clock_gen clock_gen_inst (.clock, .rst_n);

	mips_core #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) mips_core_inst (
		.clock, .rst_n, .load_en, .load_addr, .load_data, .start, .prog_len,
		.retire_valid, .retire_reg, .retire_data, .store_valid, .store_addr,
		.store_data, .done
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	// Advance the queue heads after each observed pulse
	always @(posedge clock) begin
		if (rst_n && retire_valid)
			ret_seen <= ret_seen + 1;
		if (rst_n && store_valid)
			st_seen <= st_seen + 1;
	end

	a_idle_before_start: assert property (@(posedge clock) disable iff (!rst_n)
		!started |-> !done && !retire_valid && !store_valid)
		else report_failure("done, retire or store was active before the first start");

	a_retire_expected: assert property (@(posedge clock) disable iff (!rst_n)
		retire_valid |-> ret_seen < ret_total)
		else report_failure("retire pulse seen with no register write left in the model");

	a_retire_reg: assert property (@(posedge clock) disable iff (!rst_n)
		retire_valid |-> retire_reg == head_ret_reg)
		else report_failure($sformatf("mismatch at %0t: retire_reg expected %0d got %0d",
			$time, $sampled(head_ret_reg), $sampled(retire_reg)));

	a_retire_data: assert property (@(posedge clock) disable iff (!rst_n)
		retire_valid |-> retire_data == head_ret_data)
		else report_failure($sformatf("mismatch at %0t: retire_data expected %h got %h",
			$time, $sampled(head_ret_data), $sampled(retire_data)));

	a_store_expected: assert property (@(posedge clock) disable iff (!rst_n)
		store_valid |-> st_seen < st_total)
		else report_failure("store pulse seen with no store left in the model");

	a_store_addr: assert property (@(posedge clock) disable iff (!rst_n)
		store_valid |-> store_addr == head_st_addr)
		else report_failure($sformatf("mismatch at %0t: store_addr expected %h got %h",
			$time, $sampled(head_st_addr), $sampled(store_addr)));

	a_store_data: assert property (@(posedge clock) disable iff (!rst_n)
		store_valid |-> store_data == head_st_data)
		else report_failure($sformatf("mismatch at %0t: store_data expected %h got %h",
			$time, $sampled(head_st_data), $sampled(store_data)));

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic word_t enc_r(funct_e fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
		logic [4:0] sh);
		return {OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t enc_i(opcode_e op, reg_idx_t rs, reg_idx_t rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic random_alu(input reg_idx_t rs, input reg_idx_t rt, input reg_idx_t rd,
		input int n_iops, output word_t insn);
		logic [31:0] pick, field;
		take_bits(1, pick);
		if (pick[0]) begin
			take_bits(4, pick);
			take_bits(5, field);
			insn = enc_r(r_functs[pick[3:0]], rs, rt, rd, field[4:0]);
		end else begin
			take_bits(3, pick);
			take_bits(16, field);
			insn = enc_i(i_ops[pick % n_iops], rs, rd, field[15:0]);
		end
	endtask

	// Sequential ISA reference, one instruction at a time
	task automatic model_run(input int len);
		word_t insn, a, b, res, simm, zimm, addr;
		reg_idx_t rs, rt, dst;
		logic [4:0] sh;
		logic wr;
		int idx;
		for (int i = 0; i < len; i++) begin
			insn = prog[i];
			rs = insn[25:21];
			rt = insn[20:16];
			sh = insn[10:6];
			simm = {{16{insn[15]}}, insn[15:0]};
			zimm = {16'h0000, insn[15:0]};
			a = model_regs[rs];
			b = model_regs[rt];
			dst = rt;
			wr = 1'b1;
			res = '0;
			case (opcode_e'(insn[31:26]))
				OP_RTYPE: begin
					dst = insn[15:11];
					case (funct_e'(insn[5:0]))
						F_ADD, F_ADDU: res = a + b;
						F_SUB, F_SUBU: res = a - b;
						F_AND:  res = a & b;
						F_OR:   res = a | b;
						F_XOR:  res = a ^ b;
						F_NOR:  res = ~(a | b);
						F_SLT:  res = word_t'($signed(a) < $signed(b));
						F_SLTU: res = word_t'(a < b);
						F_SLL:  res = b << sh;
						F_SRL:  res = b >> sh;
						F_SRA:  res = word_t'($signed(b) >>> sh);
						F_SLLV: res = b << a[4:0];
						F_SRLV: res = b >> a[4:0];
						F_SRAV: res = word_t'($signed(b) >>> a[4:0]);
						default: wr = 1'b0;
					endcase
				end
				OP_ADDI, OP_ADDIU: res = a + simm;
				OP_SLTI:  res = word_t'($signed(a) < $signed(simm));
				OP_SLTIU: res = word_t'(a < simm);
				OP_ORI:   res = a | zimm;
				OP_XORI:  res = a ^ zimm;
				OP_LUI:   res = {insn[15:0], 16'h0000};
				OP_LW: begin
					idx = int'(((a + simm) >> 2) % DMEM_WORDS);
					res = model_mem[idx];
				end
				OP_SW: begin
					wr = 1'b0;
					addr = a + simm;
					idx = int'((addr >> 2) % DMEM_WORDS);
					model_mem[idx] = b;
					exp_st_addr[st_total] = addr;
					exp_st_data[st_total] = b;
					st_total++;
				end
				default: wr = 1'b0;  // Unknown opcode
			endcase
			if (wr && dst != '0) begin
				model_regs[dst] = res;
				exp_ret_reg[ret_total] = dst;
				exp_ret_data[ret_total] = res;
				ret_total++;
			end
		end
	endtask

	task automatic check_counts();
		a_retire_count: assert (ret_seen == ret_total)
			else report_failure($sformatf("mismatch at %0t: retire count expected %0d got %0d",
				$time, ret_total, ret_seen));
		a_store_count: assert (st_seen == st_total)
			else report_failure($sformatf("mismatch at %0t: store count expected %0d got %0d",
				$time, st_total, st_seen));
	endtask

	task automatic run_program(input int len);
		int waited;
		int limit;
		limit = 20 * len + 40;
		for (int i = 0; i < len; i++) begin
			@(negedge clock);
			load_en = 1'b1;
			load_addr = word_t'(i);
			load_data = prog[i];
		end
		@(negedge clock);
		load_en = 1'b0;
		model_run(len);
		prog_len = word_t'(len);
		start = 1'b1;
		started = 1'b1;
		@(negedge clock);
		start = 1'b0;
		waited = 0;
		while (!done) begin
			if (waited >= limit)
				report_failure($sformatf("done did not rise within %0d cycles", limit));
			else begin
				@(negedge clock);
				waited++;
			end
		end
		check_counts();
	endtask

	task automatic wait_for_reset();
		int waited;
		waited = 0;
		@(negedge clock);
		while (rst_n !== 1'b1) begin
			if (waited >= 20)
				report_failure("reset was never released");
			else begin
				@(negedge clock);
				waited++;
			end
		end
	endtask

	task automatic build_random(input int len);
		logic [31:0] r;
		word_t insn;
		for (int i = 0; i < len; i++) begin
			take_bits(12, r);  // Registers 0 to 15 for frequent reuse
			random_alu(reg_idx_t'(r[3:0]), reg_idx_t'(r[7:4]), reg_idx_t'(r[11:8]), 7, insn);
			prog[i] = insn;
		end
	endtask

	// Every instruction reads the one before it
	task automatic build_chain(input int len);
		word_t insn;
		reg_idx_t prev, dst;
		prog[0] = enc_i(OP_LUI, 5'd0, 5'd1, 16'h8a31);
		prev = 5'd1;
		for (int i = 1; i < len; i++) begin
			dst = reg_idx_t'(1 + (i % 15));
			random_alu(prev, prev, dst, 6, insn);
			prog[i] = insn;
			prev = dst;
		end
	endtask

	initial begin
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		start = 1'b0;
		prog_len = '0;
		for (int i = 0; i < NUM_REGS; i++)
			model_regs[i] = '0;
		for (int i = 0; i < DMEM_WORDS; i++)
			model_mem[i] = '0;

		wait_for_reset();

		build_random(24);
		run_program(24);
		build_random(40);
		run_program(40);

		build_chain(12);
		run_program(12);

		// Store then load back
		prog[0] = enc_i(OP_LUI, 5'd0, 5'd10, 16'hdead);
		prog[1] = enc_i(OP_ORI, 5'd10, 5'd10, 16'hbeef);
		prog[2] = enc_i(OP_SW, 5'd0, 5'd10, 16'h0008);
		prog[3] = enc_i(OP_LW, 5'd0, 5'd11, 16'h0008);
		prog[4] = enc_i(OP_ADDIU, 5'd0, 5'd12, 16'h0010);
		prog[5] = enc_i(OP_SW, 5'd12, 5'd11, 16'h0004);
		prog[6] = enc_i(OP_LW, 5'd12, 5'd13, 16'h0004);
		prog[7] = enc_r(F_XOR, 5'd13, 5'd10, 5'd14, 5'd0);
		prog[8] = enc_i(OP_LW, 5'd0, 5'd15, 16'h000c);
		run_program(9);

		// Writes to r0 and an unknown opcode
		prog[0] = enc_i(OP_ADDIU, 5'd0, 5'd0, 16'h0055);
		prog[1] = enc_r(F_ADDU, 5'd10, 5'd10, 5'd0, 5'd0);
		prog[2] = 32'hfc00_0000;
		prog[3] = enc_r(F_ADDU, 5'd0, 5'd0, 5'd7, 5'd0);
		prog[4] = enc_r(F_OR, 5'd0, 5'd10, 5'd8, 5'd0);
		prog[5] = enc_r(F_SLL, 5'd0, 5'd0, 5'd9, 5'd4);
		run_program(6);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
logic/mips_pkg.sv
logic/fetch_unit.sv
logic/decode_stage.sv
logic/register_file.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/mips_core.sv
bench/clock_gen.sv
bench/mips_core_tb.sv

/* logic/decode_stage.sv */
`default_nettype none
`timescale 1ns/10ps

module decode_stage import mips_pkg::*; (
	input  wire         clock,
	input  wire         rst_n,
	input  logic        f_valid,
	input  word_t       f_insn,
	input  word_t       f_pc,
	output reg_idx_t    rs_idx,
	output reg_idx_t    rt_idx,
	input  word_t       rs_data,
	input  word_t       rt_data,
	input  logic        wb_en,
	input  reg_idx_t    wb_reg,
	output logic        stall,
	output logic        d_valid,
	output alu_op_e     d_op,
	output reg_idx_t    d_dest,
	output logic        d_writes,
	output logic        d_mem_read,
	output logic        d_mem_write,
	output word_t       d_rs_val,
	output word_t       d_rt_val,
	output word_t       d_imm,
	output logic [4:0]  d_shamt
);

	opcode_e opc;
	funct_e fn;
	alu_op_e op;
	reg_idx_t dest;
	logic writes, mem_read, mem_write;
	logic use_rs, use_rt, use_imm, zero_ext, var_shift;
	logic issue;
	word_t imm_ext;
	logic [NUM_REGS-1:0] pending, live, clr_mask, set_mask;

	assign opc = insn_opcode(f_insn);
	assign fn = insn_funct(f_insn);
	assign rs_idx = insn_rs(f_insn);
	assign rt_idx = insn_rt(f_insn);

	always_comb begin
		op = ALU_PASS;
		dest = insn_rt(f_insn);
		writes = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		use_rs = 1'b0;
		use_rt = 1'b0;
		use_imm = 1'b0;
		zero_ext = 1'b0;
		var_shift = 1'b0;
		case (opc)
			OP_RTYPE: begin
				dest = insn_rd(f_insn);
				writes = 1'b1;
				use_rs = 1'b1;
				use_rt = 1'b1;
				case (fn)
					F_ADD, F_ADDU: op = ALU_ADD;
					F_SUB, F_SUBU: op = ALU_SUB;
					F_AND:  op = ALU_AND;
					F_OR:   op = ALU_OR;
					F_XOR:  op = ALU_XOR;
					F_NOR:  op = ALU_NOR;
					F_SLT:  op = ALU_SLT;
					F_SLTU: op = ALU_SLTU;
					F_SLL, F_SLLV: op = ALU_SLL;
					F_SRL, F_SRLV: op = ALU_SRL;
					F_SRA, F_SRAV: op = ALU_SRA;
					default: begin  // Unknown function is a no-op
						writes = 1'b0;
						use_rs = 1'b0;
						use_rt = 1'b0;
					end
				endcase
				// Fixed shifts take shamt and read rt only
				if (fn inside {F_SLL, F_SRL, F_SRA})
					use_rs = 1'b0;
				var_shift = fn inside {F_SLLV, F_SRLV, F_SRAV};
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ORI, OP_XORI, OP_LUI: begin
				writes = 1'b1;
				use_imm = 1'b1;
				use_rs = (opc != OP_LUI);
				zero_ext = opc inside {OP_ORI, OP_XORI};
				case (opc)
					OP_SLTI:  op = ALU_SLT;
					OP_SLTIU: op = ALU_SLTU;
					OP_ORI:   op = ALU_OR;
					OP_XORI:  op = ALU_XOR;
					OP_LUI:   op = ALU_LUI;
					default:  op = ALU_ADD;
				endcase
			end
			OP_LW, OP_SW: begin  // Address is rs plus offset
				op = ALU_ADD;
				use_rs = 1'b1;
				mem_read = (opc == OP_LW);
				mem_write = (opc == OP_SW);
				writes = mem_read;
				use_rt = mem_write;  // Store data
			end
			default:  ;
		endcase
	end

	assign imm_ext = zero_ext ? {16'h0000, insn_imm(f_insn)}
		: {{16{f_insn[15]}}, insn_imm(f_insn)};

	// Writeback in this cycle is already visible through the register file
	assign clr_mask = wb_en ? (NUM_REGS'(1) << wb_reg) : '0;
	assign live = pending & ~clr_mask;

	// Dest check keeps one writer in flight per register
	assign stall = f_valid && ((use_rs && live[rs_idx]) || (use_rt && live[rt_idx])
		|| (writes && live[dest]));
	assign issue = f_valid && !stall;

	assign set_mask = (issue && writes && dest != '0) ? (NUM_REGS'(1) << dest) : '0;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pending <= '0;
			d_valid <= 1'b0;
			d_writes <= 1'b0;
			d_mem_read <= 1'b0;
			d_mem_write <= 1'b0;
		end else begin
			pending <= live | set_mask;
			d_valid <= issue;
			d_writes <= issue & writes;
			d_mem_read <= issue & mem_read;
			d_mem_write <= issue & mem_write;
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			d_op <= op;
			d_dest <= dest;
			d_rs_val <= rs_data;
			d_rt_val <= use_imm ? imm_ext : rt_data;  // Operand b for ALU ops
			d_imm <= imm_ext;
			d_shamt <= var_shift ? rs_data[4:0] : insn_shamt(f_insn);
		end
	end

	a_known_insn: assert property (@(posedge clock) disable iff (!rst_n)
		f_valid |-> !$isunknown({f_insn, f_pc}));

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`default_nettype none
`timescale 1ns/10ps

module execute_stage import mips_pkg::*; (
	input  wire         clock,
	input  wire         rst_n,
	input  logic        d_valid,
	input  alu_op_e     d_op,
	input  reg_idx_t    d_dest,
	input  logic        d_writes,
	input  logic        d_mem_read,
	input  logic        d_mem_write,
	input  word_t       d_rs_val,
	input  word_t       d_rt_val,
	input  word_t       d_imm,
	input  logic [4:0]  d_shamt,
	output logic        x_valid,
	output word_t       x_result,
	output word_t       x_store_data,
	output reg_idx_t    x_dest,
	output logic        x_writes,
	output logic        x_mem_read,
	output logic        x_mem_write
);

	word_t op_a, op_b, alu_out;
	logic is_mem;

	assign is_mem = d_mem_read | d_mem_write;
	assign op_a = d_rs_val;
	// Loads and stores add the offset, rt holds the store data
	assign op_b = is_mem ? d_imm : d_rt_val;

	always_comb begin
		case (d_op)
			ALU_ADD:  alu_out = op_a + op_b;
			ALU_SUB:  alu_out = op_a - op_b;
			ALU_AND:  alu_out = op_a & op_b;
			ALU_OR:   alu_out = op_a | op_b;
			ALU_XOR:  alu_out = op_a ^ op_b;
			ALU_NOR:  alu_out = ~(op_a | op_b);
			ALU_SLT:  alu_out = word_t'($signed(op_a) < $signed(op_b));
			ALU_SLTU: alu_out = word_t'(op_a < op_b);
			ALU_SLL:  alu_out = op_b << d_shamt;
			ALU_SRL:  alu_out = op_b >> d_shamt;
			ALU_SRA:  alu_out = word_t'($signed(op_b) >>> d_shamt);
			ALU_LUI:  alu_out = {op_b[15:0], 16'h0000};
			default:  alu_out = op_b;  // Pass
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			x_valid <= 1'b0;
			x_writes <= 1'b0;
			x_mem_read <= 1'b0;
			x_mem_write <= 1'b0;
		end else begin
			x_valid <= d_valid;
			x_writes <= d_valid & d_writes;
			x_mem_read <= d_valid & d_mem_read;
			x_mem_write <= d_valid & d_mem_write;
		end
	end

	always_ff @(posedge clock) begin
		if (d_valid) begin
			x_result <= alu_out;
			x_store_data <= d_rt_val;
			x_dest <= d_dest;
		end
	end

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module fetch_unit import mips_pkg::*; #(
	parameter int IMEM_WORDS = 64
) (
	input  wire        clock,
	input  wire        rst_n,
	input  logic       load_en,
	input  word_t      load_addr,  // Word index, not byte address
	input  word_t      load_data,
	input  logic       start,
	input  word_t      prog_len,
	input  logic       stall,
	output logic       f_valid,
	output word_t      f_insn,
	output word_t      f_pc,
	output logic       fetch_busy
);

	localparam int IMEM_AW = $clog2(IMEM_WORDS);

	word_t imem [IMEM_WORDS];
	logic running;
	word_t pc;
	word_t issued;
	logic [IMEM_AW-1:0] fetch_idx;

	assign fetch_idx = pc[2 +: IMEM_AW];  // Wraps modulo depth
	assign fetch_busy = running | f_valid;

	always_ff @(posedge clock) begin
		if (load_en)
			imem[load_addr[IMEM_AW-1:0]] <= load_data;
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			running <= 1'b0;
			pc <= '0;
			issued <= '0;
			f_valid <= 1'b0;
		end else if (start) begin
			running <= (prog_len != '0);
			pc <= '0;
			issued <= '0;
			f_valid <= 1'b0;
		end else if (!stall) begin
			f_valid <= running;
			if (running) begin
				pc <= pc + 32'd4;
				issued <= issued + 32'd1;
				if (issued + 32'd1 == prog_len)
					running <= 1'b0;
			end
		end
	end

	// Held while decode stalls
	always_ff @(posedge clock) begin
		if (running && !stall && !start) begin
			f_insn <= imem[fetch_idx];
			f_pc <= pc;
		end
	end

	a_no_load_while_running: assert property (@(posedge clock) disable iff (!rst_n)
		running |-> !load_en);

endmodule

`default_nettype wire

/* logic/mips_core.sv */
`default_nettype none
`timescale 1ns/10ps

module mips_core import mips_pkg::*; #(
	parameter int IMEM_WORDS = 64,
	parameter int DMEM_WORDS = 64
) (
	input  wire       clock,
	input  wire       rst_n,
	input  logic      load_en,
	input  word_t     load_addr,
	input  word_t     load_data,
	input  logic      start,
	input  word_t     prog_len,
	output logic      retire_valid,
	output reg_idx_t  retire_reg,
	output word_t     retire_data,
	output logic      store_valid,
	output word_t     store_addr,
	output word_t     store_data,
	output logic      done
);

	logic f_valid, fetch_busy, stall;
	word_t f_insn, f_pc;
	reg_idx_t rs_idx, rt_idx;
	word_t rs_data, rt_data;
	logic d_valid, d_writes, d_mem_read, d_mem_write;
	alu_op_e d_op;
	reg_idx_t d_dest;
	word_t d_rs_val, d_rt_val, d_imm;
	logic [4:0] d_shamt;
	logic x_valid, x_writes, x_mem_read, x_mem_write;
	word_t x_result, x_store_data;
	reg_idx_t x_dest;
	logic wb_en, pipe_busy;
	reg_idx_t wb_reg;
	word_t wb_data;

	fetch_unit #(.IMEM_WORDS(IMEM_WORDS)) fetch_unit_inst (
		.clock, .rst_n, .load_en, .load_addr, .load_data, .start, .prog_len,
		.stall, .f_valid, .f_insn, .f_pc, .fetch_busy
	);

	decode_stage decode_stage_inst (
		.clock, .rst_n, .f_valid, .f_insn, .f_pc, .rs_idx, .rt_idx,
		.rs_data, .rt_data, .wb_en, .wb_reg, .stall, .d_valid, .d_op,
		.d_dest, .d_writes, .d_mem_read, .d_mem_write, .d_rs_val,
		.d_rt_val, .d_imm, .d_shamt
	);

	register_file register_file_inst (
		.clock, .rst_n, .rs_idx, .rt_idx, .rs_data, .rt_data,
		.wb_en, .wb_reg, .wb_data
	);

	execute_stage execute_stage_inst (
		.clock, .rst_n, .d_valid, .d_op, .d_dest, .d_writes, .d_mem_read,
		.d_mem_write, .d_rs_val, .d_rt_val, .d_imm, .d_shamt, .x_valid,
		.x_result, .x_store_data, .x_dest, .x_writes, .x_mem_read, .x_mem_write
	);

	result_stage #(.DMEM_WORDS(DMEM_WORDS)) result_stage_inst (
		.clock, .rst_n, .x_valid, .x_result, .x_store_data, .x_dest,
		.x_writes, .x_mem_read, .x_mem_write, .fetch_busy, .d_valid,
		.wb_en, .wb_reg, .wb_data, .retire_valid, .retire_reg, .retire_data,
		.store_valid, .store_addr, .store_data, .pipe_busy, .done
	);

	// A new program only after the previous one has drained
	a_start_when_idle: assert property (@(posedge clock) disable iff (!rst_n)
		start |-> !(fetch_busy || pipe_busy));

endmodule

`default_nettype wire

/* logic/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	localparam int WORD_W = 32;
	localparam int REG_IDX_W = 5;
	localparam int NUM_REGS = 32;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Primary opcodes, bits 31:26
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_ADDI  = 6'h08,
		OP_ADDIU = 6'h09,
		OP_SLTI  = 6'h0a,
		OP_SLTIU = 6'h0b,
		OP_ORI   = 6'h0d,
		OP_XORI  = 6'h0e,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// R-type function codes, bits 5:0
	typedef enum logic [5:0] {
		F_SLL  = 6'h00,
		F_SRL  = 6'h02,
		F_SRA  = 6'h03,
		F_SLLV = 6'h04,
		F_SRLV = 6'h06,
		F_SRAV = 6'h07,
		F_ADD  = 6'h20,
		F_ADDU = 6'h21,
		F_SUB  = 6'h22,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_XOR  = 6'h26,
		F_NOR  = 6'h27,
		F_SLT  = 6'h2a,
		F_SLTU = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
		ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASS
	} alu_op_e;

	function automatic opcode_e insn_opcode(word_t insn);
		return opcode_e'(insn[31:26]);
	endfunction

	function automatic funct_e insn_funct(word_t insn);
		return funct_e'(insn[5:0]);
	endfunction

	function automatic reg_idx_t insn_rs(word_t insn);
		return insn[25:21];
	endfunction

	function automatic reg_idx_t insn_rt(word_t insn);
		return insn[20:16];
	endfunction

	function automatic reg_idx_t insn_rd(word_t insn);
		return insn[15:11];
	endfunction

	function automatic logic [4:0] insn_shamt(word_t insn);
		return insn[10:6];
	endfunction

	function automatic logic [15:0] insn_imm(word_t insn);
		return insn[15:0];
	endfunction

endpackage

`default_nettype wire

/* logic/register_file.sv */
`default_nettype none
`timescale 1ns/10ps

module register_file import mips_pkg::*; (
	input  wire       clock,
	input  wire       rst_n,
	input  reg_idx_t  rs_idx,
	input  reg_idx_t  rt_idx,
	output word_t     rs_data,
	output word_t     rt_data,
	input  logic      wb_en,
	input  reg_idx_t  wb_reg,
	input  word_t     wb_data
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb_en && wb_reg != '0) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// Write-through so decode sees the result in the writeback cycle
	assign rs_data = (rs_idx == '0) ? '0
		: (wb_en && wb_reg == rs_idx) ? wb_data : regs[rs_idx];
	assign rt_data = (rt_idx == '0) ? '0
		: (wb_en && wb_reg == rt_idx) ? wb_data : regs[rt_idx];

endmodule

`default_nettype wire

/* logic/result_stage.sv */
`default_nettype none
`timescale 1ns/10ps

module result_stage import mips_pkg::*; #(
	parameter int DMEM_WORDS = 64
) (
	input  wire       clock,
	input  wire       rst_n,
	input  logic      x_valid,
	input  word_t     x_result,
	input  word_t     x_store_data,
	input  reg_idx_t  x_dest,
	input  logic      x_writes,
	input  logic      x_mem_read,
	input  logic      x_mem_write,
	input  logic      fetch_busy,
	input  logic      d_valid,
	output logic      wb_en,
	output reg_idx_t  wb_reg,
	output word_t     wb_data,
	output logic      retire_valid,
	output reg_idx_t  retire_reg,
	output word_t     retire_data,
	output logic      store_valid,
	output word_t     store_addr,
	output word_t     store_data,
	output logic      pipe_busy,
	output logic      done
);

	localparam int DMEM_AW = $clog2(DMEM_WORDS);

	typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE} run_state_e;

	word_t dmem [DMEM_WORDS];
	logic [DMEM_AW-1:0] dmem_idx;
	run_state_e state;

	assign dmem_idx = DMEM_AW'((x_result >> 2) % DMEM_WORDS);

	assign wb_en = x_valid && x_writes && x_dest != '0;
	assign wb_reg = x_dest;
	assign wb_data = x_mem_read ? dmem[dmem_idx] : x_result;  // Combinational load

	assign retire_valid = wb_en;
	assign retire_reg = wb_reg;
	assign retire_data = wb_data;

	assign store_valid = x_valid & x_mem_write;
	assign store_addr = x_result;
	assign store_data = x_store_data;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= '0;
		end else if (store_valid) begin
			dmem[dmem_idx] <= x_store_data;
		end
	end

	assign pipe_busy = d_valid | x_valid;
	// Drops as soon as a new program starts fetching
	assign done = (state == S_DONE) && !fetch_busy;

	// Nothing upstream means the result stage holds the last instruction
	always_ff @(posedge clock) begin
		if (!rst_n)
			state <= S_IDLE;
		else if (fetch_busy)
			state <= S_RUN;
		else if (state == S_RUN && !d_valid)
			state <= S_DONE;
	end

	a_store_aligned: assert property (@(posedge clock) disable iff (!rst_n)
		store_valid |-> store_addr[1:0] == 2'b00);

endmodule

`default_nettype wire
